// ==== source/afu_params.svh ====
`ifndef AFU_PARAMS_SVH
`define AFU_PARAMS_SVH

// ----------------------------------------
// Stream geometry
// ----------------------------------------

// Width of one stream beat in bits
`define AFU_DATA_W 64

// Segments per beat, each 32 bits wide with 4 keep bits
`define AFU_NUM_SEG 2

// Keep bits per beat, one per byte
`define AFU_KEEP_W (`AFU_DATA_W / 8)

// ----------------------------------------
// Engine sizing
// ----------------------------------------

// Echo FIFO depth in beats, a power of two
`define AFU_ECHO_DEPTH 16

`endif

// ==== source/afu_pkg.sv ====
package afu_pkg;

`include "afu_params.svh"

   // Opcode in bits [63:62] of the first beat
   // OP_STATUS appears only in responses
   typedef enum logic [1:0] {
      OP_ECHO   = 2'd0,
      OP_REPORT = 2'd1,
      OP_DROP   = 2'd2,
      OP_STATUS = 2'd3
   } opcode_e;

   // Internal stream beat
   typedef struct packed {
      logic [`AFU_DATA_W-1:0] data;
      logic [`AFU_KEEP_W-1:0] keep;
      logic                   last;
   } stream_t;

   // Host RX beat
   typedef struct packed {
      logic [`AFU_DATA_W-1:0] data;
      logic [`AFU_KEEP_W-1:0] keep;
      logic                   last;
   } plat_rx_t;

   // Host TX beat with explicit SOP and per-segment EOP
   typedef struct packed {
      logic [`AFU_DATA_W-1:0]  data;
      logic [`AFU_KEEP_W-1:0]  keep;
      logic                    last;
      logic                    sop;
      logic [`AFU_NUM_SEG-1:0] eop;
   } plat_tx_t;

   // Status payload, opcode lands in the top bits of the beat
   typedef struct packed {
      opcode_e     opcode;
      logic [13:0] padding;
      logic [15:0] echo_count;
      logic [15:0] report_count;
      logic [15:0] drop_count;
   } report_t;

   // Arbiter grant
   typedef enum logic {
      ENG_ECHO   = 1'b0,
      ENG_REPORT = 1'b1
   } eng_sel_e;

endpackage

// ==== source/host_chan_adapter.sv ====
`timescale 1ns/1ps

`include "afu_params.svh"

module host_chan_adapter (
   input  logic               plat_ifc,
   input  logic               rst,
   input  afu_pkg::plat_rx_t  host_rx,
   input  logic               host_rx_valid,
   output logic               host_rx_ready,
   output afu_pkg::stream_t   rx_stream,
   output logic               rx_valid,
   input  logic               rx_ready,
   input  afu_pkg::stream_t   tx_stream,
   input  logic               tx_valid,
   output logic               tx_ready,
   output afu_pkg::plat_tx_t  host_tx,
   output logic               host_tx_valid,
   input  logic               host_tx_ready
);

   // Bytes per segment, used to find the first keep bit of each segment
   localparam int SEG_BYTES = `AFU_KEEP_W / `AFU_NUM_SEG;

   // Next TX beat opens a packet
   logic tx_sop;

   // ----------------------------------------
   // RX: host to AFU
   // ----------------------------------------

   assign rx_stream.data = host_rx.data;
   assign rx_stream.keep = host_rx.keep;
   assign rx_stream.last = host_rx.last;
   assign rx_valid       = host_rx_valid;
   assign host_rx_ready  = rx_ready;

   // ----------------------------------------
   // TX: AFU to host
   // ----------------------------------------

   assign host_tx_valid = tx_valid;
   assign tx_ready      = host_tx_ready;

   always_comb
   begin
      host_tx.data = tx_stream.data;
      host_tx.keep = tx_stream.keep;
      host_tx.last = tx_stream.last;
      host_tx.sop  = tx_sop;
      // Only the highest segment holding payload carries EOP
      // Later segments override earlier ones
      host_tx.eop  = '0;
      for (int s = 0; s < `AFU_NUM_SEG; s++)
      begin
         if (tx_stream.keep[s * SEG_BYTES])
         begin
            host_tx.eop    = '0;
            host_tx.eop[s] = tx_stream.last;
         end
      end
   end

   // SOP tracking, reopens after each accepted last beat
   always_ff @(posedge plat_ifc)
   begin
      if (rst)
      begin
         tx_sop <= 1'b1;
      end
      else if (tx_valid && host_tx_ready)
      begin
         tx_sop <= tx_stream.last;
      end
   end

   // Arbiter must keep a stalled TX beat steady until the host takes it
   tx_hold_a : assert property (@(posedge plat_ifc) disable iff (rst)
      host_tx_valid && !host_tx_ready |=> host_tx_valid && $stable(host_tx))
      else $error("host_tx beat changed or dropped before acceptance");

endmodule

// ==== source/rx_dispatch.sv ====
`timescale 1ns/1ps

`include "afu_params.svh"

module rx_dispatch (
   input  logic              plat_ifc,
   input  logic              rst,
   input  afu_pkg::stream_t  rx_stream,
   input  logic              rx_valid,
   output logic              rx_ready,
   output afu_pkg::stream_t  echo_in,
   output logic              echo_valid,
   input  logic              echo_ready,
   output logic              report_req,
   input  logic              report_ready,
   output logic [15:0]       echo_count,
   output logic [15:0]       report_count,
   output logic [15:0]       drop_count
);

   typedef enum logic {
      S_HEAD,
      S_BODY
   } state_e;

   state_e            state_q;
   afu_pkg::opcode_e  head_op;
   afu_pkg::opcode_e  dest_op;
   afu_pkg::opcode_e  dest_q;
   logic              head_beat;
   logic              rx_fire;

   // Opcode sits in the two top bits of the first beat
   assign head_op   = afu_pkg::opcode_e'(rx_stream.data[`AFU_DATA_W-1 -: 2]);
   assign head_beat = (state_q == S_HEAD);
   // Destination is decoded live on the head, latched for the body
   assign dest_op   = head_beat ? head_op : dest_q;
   assign rx_fire   = rx_valid && rx_ready;
   assign echo_in   = rx_stream;

   // ----------------------------------------
   // Steering
   // ----------------------------------------

   always_comb
   begin
      echo_valid = 1'b0;
      report_req = 1'b0;
      rx_ready   = 1'b1;
      case (dest_op)
         afu_pkg::OP_ECHO:
         begin
            echo_valid = rx_valid;
            rx_ready   = echo_ready;
         end
         afu_pkg::OP_REPORT:
         begin
            // Head waits for a free report slot, body beats are absorbed
            if (head_beat)
            begin
               rx_ready   = report_ready;
               report_req = rx_valid && report_ready;
            end
         end
         default:
         begin
            // Drop, and a stray status opcode from the host, sink everything
            rx_ready = 1'b1;
         end
      endcase
   end

   // ----------------------------------------
   // Packet state and counters
   // ----------------------------------------

   always_ff @(posedge plat_ifc)
   begin
      if (rst)
      begin
         state_q      <= S_HEAD;
         dest_q       <= afu_pkg::OP_DROP;
         echo_count   <= '0;
         report_count <= '0;
         drop_count   <= '0;
      end
      else if (rx_fire)
      begin
         if (head_beat)
         begin
            dest_q <= head_op;
            case (head_op)
               afu_pkg::OP_ECHO:   echo_count   <= echo_count + 16'd1;
               afu_pkg::OP_REPORT: report_count <= report_count + 16'd1;
               default:            drop_count   <= drop_count + 16'd1;
            endcase
         end
         state_q <= rx_stream.last ? S_HEAD : S_BODY;
      end
   end

   // Request only into a free report slot, which the engine then occupies
   report_req_a : assert property (@(posedge plat_ifc) disable iff (rst)
      report_req |-> report_ready ##1 !report_ready)
      else $error("report_req issued without a free report slot");

endmodule

// ==== source/lb_echo_engine.sv ====
`timescale 1ns/1ps

`include "afu_params.svh"

module lb_echo_engine (
   input  logic              plat_ifc,
   input  logic              rst,
   input  afu_pkg::stream_t  echo_in,
   input  logic              echo_valid,
   output logic              echo_ready,
   output afu_pkg::stream_t  out_stream,
   output logic              out_valid,
   input  logic              out_ready
);

   localparam int DEPTH = `AFU_ECHO_DEPTH;
   localparam int AW    = $clog2(DEPTH);

   // Beat storage
   afu_pkg::stream_t mem [DEPTH];

   // Pointers carry one wrap bit above the index
   logic [AW:0] wr_ptr;
   logic [AW:0] rd_ptr;
   logic        full;
   logic        empty;
   logic        wr;
   logic        rd;

   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

   assign echo_ready = !full;
   assign wr         = echo_valid && echo_ready;

   assign out_valid  = !empty;
   assign out_stream = mem[rd_ptr[AW-1:0]];
   assign rd         = out_valid && out_ready;

   // ----------------------------------------
   // Storage write
   // ----------------------------------------

   always_ff @(posedge plat_ifc)
   begin
      if (wr)
      begin
         mem[wr_ptr[AW-1:0]] <= echo_in;
      end
   end

   // ----------------------------------------
   // Pointers
   // ----------------------------------------

   always_ff @(posedge plat_ifc)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (wr)
         begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // A beat refused while the FIFO is full stays on the input until written
   full_hold_a : assert property (@(posedge plat_ifc) disable iff (rst)
      echo_valid && full |=> echo_valid && $stable(echo_in))
      else $error("echo beat changed or dropped while the FIFO was full");

endmodule

// ==== source/lb_report_engine.sv ====
`timescale 1ns/1ps

module lb_report_engine (
   input  logic              plat_ifc,
   input  logic              rst,
   input  logic              report_req,
   output logic              report_ready,
   input  logic [15:0]       echo_count,
   input  logic [15:0]       report_count,
   input  logic [15:0]       drop_count,
   output afu_pkg::stream_t  out_stream,
   output logic              out_valid,
   input  logic              out_ready
);

   // One status beat waiting for the arbiter
   logic             pending_q;
   afu_pkg::report_t payload_q;

   assign report_ready = !pending_q;
   assign out_valid    = pending_q;

   // Single-beat response, all bytes valid
   assign out_stream.data = payload_q;
   assign out_stream.keep = '1;
   assign out_stream.last = 1'b1;

   // ----------------------------------------
   // Payload capture
   // ----------------------------------------

   always_ff @(posedge plat_ifc)
   begin
      if (report_req)
      begin
         payload_q.opcode       <= afu_pkg::OP_STATUS;
         payload_q.padding      <= '0;
         payload_q.echo_count   <= echo_count;
         payload_q.report_count <= report_count;
         payload_q.drop_count   <= drop_count;
      end
   end

   // Request and send never overlap since requests need an empty slot
   always_ff @(posedge plat_ifc)
   begin
      if (rst)
      begin
         pending_q <= 1'b0;
      end
      else if (report_req)
      begin
         pending_q <= 1'b1;
      end
      else if (out_valid && out_ready)
      begin
         pending_q <= 1'b0;
      end
   end

endmodule

// ==== source/tx_arbiter.sv ====
`timescale 1ns/1ps

module tx_arbiter (
   input  logic              plat_ifc,
   input  logic              rst,
   input  afu_pkg::stream_t  echo_stream,
   input  logic              echo_valid,
   output logic              echo_ready,
   input  afu_pkg::stream_t  report_stream,
   input  logic              report_valid,
   output logic              report_ready,
   output afu_pkg::stream_t  tx_stream,
   output logic              tx_valid,
   input  logic              tx_ready
);

   // Last served engine, and packet lock once a beat is presented
   afu_pkg::eng_sel_e grant_q;
   logic              lock_q;
   afu_pkg::eng_sel_e pick;
   afu_pkg::eng_sel_e sel;

   // Round robin, the other engine goes first when both wait
   always_comb
   begin
      if (grant_q == afu_pkg::ENG_ECHO)
      begin
         pick = report_valid ? afu_pkg::ENG_REPORT : afu_pkg::ENG_ECHO;
      end
      else
      begin
         pick = echo_valid ? afu_pkg::ENG_ECHO : afu_pkg::ENG_REPORT;
      end
   end

   assign sel = lock_q ? grant_q : pick;

   // Datapath mux
   assign tx_stream    = (sel == afu_pkg::ENG_ECHO) ? echo_stream : report_stream;
   assign tx_valid     = (sel == afu_pkg::ENG_ECHO) ? echo_valid : report_valid;
   assign echo_ready   = tx_ready && (sel == afu_pkg::ENG_ECHO);
   assign report_ready = tx_ready && (sel == afu_pkg::ENG_REPORT);

   // Lock holds from the first presented beat until its last beat leaves
   always_ff @(posedge plat_ifc)
   begin
      if (rst)
      begin
         grant_q <= afu_pkg::ENG_REPORT;
         lock_q  <= 1'b0;
      end
      else if (tx_valid)
      begin
         grant_q <= sel;
         lock_q  <= !(tx_ready && tx_stream.last);
      end
   end

   grant_stable_a : assert property (@(posedge plat_ifc) disable iff (rst)
      tx_valid && !(tx_ready && tx_stream.last) |=> sel == $past(sel))
      else $error("grant moved while a packet was open");

endmodule

// ==== source/plat_afu_top.sv ====
`timescale 1ns/1ps

module plat_afu_top (
   input  logic               plat_ifc,
   input  logic               rst,
   input  afu_pkg::plat_rx_t  host_rx,
   input  logic               host_rx_valid,
   output logic               host_rx_ready,
   output afu_pkg::plat_tx_t  host_tx,
   output logic               host_tx_valid,
   input  logic               host_tx_ready
);

   // ----------------------------------------
   // Internal streams
   // ----------------------------------------

   afu_pkg::stream_t rx_stream;
   logic             rx_valid;
   logic             rx_ready;

   afu_pkg::stream_t echo_in;
   logic             echo_in_valid;
   logic             echo_in_ready;

   afu_pkg::stream_t echo_out;
   logic             echo_out_valid;
   logic             echo_out_ready;

   afu_pkg::stream_t report_out;
   logic             report_out_valid;
   logic             report_out_ready;

   afu_pkg::stream_t tx_stream;
   logic             tx_valid;
   logic             tx_ready;

   // Report request path
   logic        report_req;
   logic        report_ready;
   logic [15:0] echo_count;
   logic [15:0] report_count;
   logic [15:0] drop_count;

   host_chan_adapter i_host_chan_adapter (
      .plat_ifc      (plat_ifc),
      .rst           (rst),
      .host_rx       (host_rx),
      .host_rx_valid (host_rx_valid),
      .host_rx_ready (host_rx_ready),
      .rx_stream     (rx_stream),
      .rx_valid      (rx_valid),
      .rx_ready      (rx_ready),
      .tx_stream     (tx_stream),
      .tx_valid      (tx_valid),
      .tx_ready      (tx_ready),
      .host_tx       (host_tx),
      .host_tx_valid (host_tx_valid),
      .host_tx_ready (host_tx_ready)
   );

   rx_dispatch i_rx_dispatch (
      .plat_ifc     (plat_ifc),
      .rst          (rst),
      .rx_stream    (rx_stream),
      .rx_valid     (rx_valid),
      .rx_ready     (rx_ready),
      .echo_in      (echo_in),
      .echo_valid   (echo_in_valid),
      .echo_ready   (echo_in_ready),
      .report_req   (report_req),
      .report_ready (report_ready),
      .echo_count   (echo_count),
      .report_count (report_count),
      .drop_count   (drop_count)
   );

   lb_echo_engine i_lb_echo_engine (
      .plat_ifc   (plat_ifc),
      .rst        (rst),
      .echo_in    (echo_in),
      .echo_valid (echo_in_valid),
      .echo_ready (echo_in_ready),
      .out_stream (echo_out),
      .out_valid  (echo_out_valid),
      .out_ready  (echo_out_ready)
   );

   lb_report_engine i_lb_report_engine (
      .plat_ifc     (plat_ifc),
      .rst          (rst),
      .report_req   (report_req),
      .report_ready (report_ready),
      .echo_count   (echo_count),
      .report_count (report_count),
      .drop_count   (drop_count),
      .out_stream   (report_out),
      .out_valid    (report_out_valid),
      .out_ready    (report_out_ready)
   );

   // Packet-atomic merge of both engines onto the TX stream
   tx_arbiter i_tx_arbiter (
      .plat_ifc      (plat_ifc),
      .rst           (rst),
      .echo_stream   (echo_out),
      .echo_valid    (echo_out_valid),
      .echo_ready    (echo_out_ready),
      .report_stream (report_out),
      .report_valid  (report_out_valid),
      .report_ready  (report_out_ready),
      .tx_stream     (tx_stream),
      .tx_valid      (tx_valid),
      .tx_ready      (tx_ready)
   );

endmodule

// ==== test/plat_afu_model.svh ====
`ifndef PLAT_AFU_MODEL_SVH
`define PLAT_AFU_MODEL_SVH

// ----------------------------------------
// Model state
// ----------------------------------------

// Expected echo beats and status payloads, in send order
afu_pkg::stream_t echo_q[$];
afu_pkg::report_t report_q[$];

// Packet counters as the host has sent them
logic [15:0]      n_echo = '0;
logic [15:0]      n_report = '0;
logic [15:0]      n_drop = '0;

// RX packet tracking
logic             rx_open = 1'b0;
afu_pkg::opcode_e rx_op = afu_pkg::OP_DROP;

// Bookkeeping for the running test
string            test_name = "reset";
int               error_count = 0;
int               check_count = 0;

// ----------------------------------------
// Compare tasks
// ----------------------------------------

task automatic check_beat(input afu_pkg::plat_tx_t exp, input afu_pkg::plat_tx_t act);
   check_count++;
   if (act !== exp)
   begin
      error_count++;
      $display("Fail %s: tx beat expected %h actual %h", test_name, exp, act);
   end
endtask

task automatic check_report(input afu_pkg::report_t exp, input afu_pkg::report_t act);
   check_count++;
   if (act !== exp)
   begin
      error_count++;
      $display("Fail %s: status payload expected %h actual %h", test_name, exp, act);
   end
endtask

// ----------------------------------------
// Expected TX beat
// ----------------------------------------

// SOP on first beats, EOP only in the highest segment with payload
function automatic afu_pkg::plat_tx_t expect_tx(input afu_pkg::stream_t b, input logic first);
   afu_pkg::plat_tx_t t;
   logic              found;
   t.data = b.data;
   t.keep = b.keep;
   t.last = b.last;
   t.sop  = first;
   t.eop  = '0;
   found  = 1'b0;
   // Scan down from the top segment
   for (int s = `AFU_NUM_SEG - 1; s >= 0; s--)
   begin
      if (!found && b.keep[s * (`AFU_KEEP_W / `AFU_NUM_SEG)])
      begin
         t.eop[s] = b.last;
         found    = 1'b1;
      end
   end
   return t;
endfunction

// Host RX beat accepted, update counters and expectations
task automatic model_rx_beat(input afu_pkg::plat_rx_t b);
   afu_pkg::report_t rep;
   afu_pkg::stream_t s;
   if (!rx_open)
   begin
      rx_op = afu_pkg::opcode_e'(b.data[`AFU_DATA_W-1 -: 2]);
      case (rx_op)
         afu_pkg::OP_ECHO:
         begin
            n_echo++;
         end
         afu_pkg::OP_REPORT:
         begin
            // Counts seen before this request beat
            rep.opcode       = afu_pkg::OP_STATUS;
            rep.padding      = '0;
            rep.echo_count   = n_echo;
            rep.report_count = n_report;
            rep.drop_count   = n_drop;
            report_q.push_back(rep);
            n_report++;
         end
         default:
         begin
            n_drop++;
         end
      endcase
   end
   if (rx_op == afu_pkg::OP_ECHO)
   begin
      s.data = b.data;
      s.keep = b.keep;
      s.last = b.last;
      echo_q.push_back(s);
   end
   rx_open = !b.last;
endtask

`endif

// ==== test/plat_afu_tb.sv ====
`timescale 1ns/1ps

`include "afu_params.svh"

module plat_afu_tb;

   localparam int RX_TIMEOUT    = 500;
   localparam int DRAIN_TIMEOUT = 2000;

   logic              plat_ifc = 1'b0;
   logic              rst = 1'b1;
   afu_pkg::plat_rx_t host_rx = '0;
   logic              host_rx_valid = 1'b0;
   logic              host_rx_ready;
   afu_pkg::plat_tx_t host_tx;
   logic              host_tx_valid;
   logic              host_tx_ready = 1'b1;

   // TX packet tracking and test control
   logic              tx_open = 1'b0;
   logic              tx_is_report = 1'b0;
   logic              bp_on = 1'b0;
   int                tests_run = 0;
   int                tests_ok = 0;

`include "plat_afu_model.svh"

   plat_afu_top i_plat_afu_top (
      .plat_ifc      (plat_ifc),
      .rst           (rst),
      .host_rx       (host_rx),
      .host_rx_valid (host_rx_valid),
      .host_rx_ready (host_rx_ready),
      .host_tx       (host_tx),
      .host_tx_valid (host_tx_valid),
      .host_tx_ready (host_tx_ready)
   );

   always #4 plat_ifc = ~plat_ifc;

   // Host TX back-pressure, about one stalled cycle in four
   always @(negedge plat_ifc)
   begin
      host_tx_ready = bp_on ? ($urandom_range(0, 3) != 0) : 1'b1;
   end

   // ----------------------------------------
   // Monitors
   // ----------------------------------------

   task automatic take_tx_beat(input afu_pkg::plat_tx_t act);
      afu_pkg::stream_t beat;
      afu_pkg::report_t rep;
      logic             have;
      have = 1'b1;
      // First beat decides the packet class
      if (!tx_open)
      begin
         tx_is_report = (act.data[`AFU_DATA_W-1 -: 2] == afu_pkg::OP_STATUS);
      end
      if (tx_is_report && report_q.size() == 0)
      begin
         have = 1'b0;
         error_count++;
         $display("Error in %s: status packet sent with no report request", test_name);
      end
      else if (tx_is_report)
      begin
         rep       = report_q.pop_front();
         beat.data = rep;
         beat.keep = '1;
         beat.last = 1'b1;
         check_report(rep, afu_pkg::report_t'(act.data));
      end
      else if (echo_q.size() == 0)
      begin
         have = 1'b0;
         error_count++;
         $display("Error in %s: TX beat with no echo beat expected", test_name);
      end
      else
      begin
         beat = echo_q.pop_front();
      end
      if (have)
      begin
         check_beat(expect_tx(beat, !tx_open), act);
      end
      tx_open = !act.last;
   endtask

   always @(posedge plat_ifc)
   begin
      if (!rst && host_rx_valid && host_rx_ready)
      begin
         model_rx_beat(host_rx);
      end
      if (!rst && host_tx_valid && host_tx_ready)
      begin
         take_tx_beat(host_tx);
      end
   end

   // ----------------------------------------
   // Stimulus
   // ----------------------------------------

   task automatic abort_run(input string what);
      $display("Timeout in %s: %s", test_name, what);
      $display("Result: FAILED");
      $finish;
   endtask

   // Present one beat and hold it until the DUT takes it
   task automatic send_beat(input afu_pkg::plat_rx_t b);
      int waited;
      waited = 0;
      @(negedge plat_ifc);
      host_rx       = b;
      host_rx_valid = 1'b1;
      @(posedge plat_ifc);
      while (!host_rx_ready)
      begin
         waited++;
         if (waited > RX_TIMEOUT)
         begin
            abort_run("host RX ready stayed low");
         end
         @(posedge plat_ifc);
      end
   endtask

   task automatic send_packet(input afu_pkg::opcode_e op, input int len);
      afu_pkg::plat_rx_t b;
      for (int i = 0; i < len; i++)
      begin
         b.data = {$urandom, $urandom};
         if (i == 0)
         begin
            b.data[`AFU_DATA_W-1 -: 2] = op;
         end
         b.last = (i == len - 1);
         // Full keep inside a packet, any nonzero pattern on the last beat
         b.keep = b.last ? 8'($urandom_range(1, 255)) : 8'hff;
         send_beat(b);
      end
   endtask

   task automatic idle_gap(input int n);
      @(negedge plat_ifc);
      host_rx_valid = 1'b0;
      repeat (n) @(negedge plat_ifc);
   endtask

   // Wait until every expected beat has left the DUT
   task automatic drain_outputs();
      int waited;
      waited = 0;
      while (echo_q.size() != 0 || report_q.size() != 0 || tx_open)
      begin
         waited++;
         if (waited > DRAIN_TIMEOUT)
         begin
            abort_run("expected TX beats never arrived");
         end
         @(negedge plat_ifc);
      end
   endtask

   function automatic afu_pkg::opcode_e pick_op(input logic [2:0] ops);
      afu_pkg::opcode_e op;
      do
         op = afu_pkg::opcode_e'(2'($urandom_range(0, 2)));
      while (!ops[op]);
      return op;
   endfunction

   task automatic run_test(input string name, input int npkt, input logic [2:0] ops,
                           input int max_len, input logic bp);
      int err_start;
      int chk_start;
      test_name = name;
      err_start = error_count;
      chk_start = check_count;
      bp_on     = bp;
      for (int p = 0; p < npkt; p++)
      begin
         send_packet(pick_op(ops), $urandom_range(1, max_len));
         idle_gap($urandom_range(0, 2));
      end
      drain_outputs();
      bp_on = 1'b0;
      tests_run++;
      if (error_count == err_start)
      begin
         tests_ok++;
      end
      $display("Test %-14s %0d checks, %0d errors, %s", name, check_count - chk_start,
               error_count - err_start, (error_count == err_start) ? "ok" : "bad");
   endtask

   // ----------------------------------------
   // Main sequence
   // ----------------------------------------

   initial
   begin
      void'($urandom(32'h6f13_8ec2));
      repeat (16) @(posedge plat_ifc);
      @(negedge plat_ifc);
      rst = 1'b0;
      // Opcode masks: bit 0 echo, bit 1 report, bit 2 drop
      run_test("echo_order", 20, 3'b001, 6, 1'b0);
      run_test("report_counts", 20, 3'b011, 6, 1'b0);
      run_test("drop_filter", 20, 3'b110, 6, 1'b0);
      run_test("sop_eop", 30, 3'b111, 2, 1'b0);
      run_test("backpressure", 60, 3'b111, 6, 1'b1);
      // Quiet window to catch any stray TX beat
      repeat (20) @(negedge plat_ifc);
      $display("Summary: %0d of %0d tests ok, %0d checks, %0d errors",
               tests_ok, tests_run, check_count, error_count);
      if (error_count == 0 && check_count > 0)
      begin
         $display("Result: PASSED");
      end
      else
      begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// ==== flist.f ====
+incdir+source
+incdir+test
source/afu_pkg.sv
source/host_chan_adapter.sv
source/rx_dispatch.sv
source/lb_echo_engine.sv
source/lb_report_engine.sv
source/tx_arbiter.sv
source/plat_afu_top.sv
test/plat_afu_tb.sv

// ==== Bender.yml ====
package:
  name: plat_afu

sources:
  - include_dirs:
      - source
    files:
      - source/afu_pkg.sv
      - source/host_chan_adapter.sv
      - source/rx_dispatch.sv
      - source/lb_echo_engine.sv
      - source/lb_report_engine.sv
      - source/tx_arbiter.sv
      - source/plat_afu_top.sv
  - target: test
    include_dirs:
      - source
      - test
    files:
      - test/plat_afu_tb.sv
